// ==== vga_timing_pkg.sv ====
// Video timing and fetch definitions
package vga_timing_pkg;

   // ========================================
   // Screen timing, 1280x1024
   // ========================================
   localparam int H_DISP   = 1280;
   localparam int V_DISP   = 1024;

   localparam int H_FPORCH = 16;
   localparam int H_SYNC   = 100;
   localparam int H_BPORCH = 200;

   localparam int V_FPORCH = 1;
   localparam int V_SYNC   = 3;
   localparam int V_BPORCH = 38;

   localparam int H_TOTAL  = H_DISP + H_FPORCH + H_SYNC + H_BPORCH;  // 1596
   localparam int V_TOTAL  = V_DISP + V_FPORCH + V_SYNC + V_BPORCH;  // 1066

   localparam int H_SYNC_START = H_DISP + H_FPORCH;
   localparam int V_SYNC_START = V_DISP + V_FPORCH;

   // ========================================
   // Frame buffer box, centred
   // ========================================
   localparam int BOX_WIDTH    = 768;
   localparam int BOX_HEIGHT   = 896;
   localparam int H_BOX_OFFSET = (H_DISP - BOX_WIDTH) / 2;   // 256
   localparam int V_BOX_OFFSET = (V_DISP - BOX_HEIGHT) / 2;  // 64
   localparam int H_BOX_END    = H_BOX_OFFSET + BOX_WIDTH;
   localparam int V_BOX_END    = V_BOX_OFFSET + BOX_HEIGHT;

   // Fetch schedule, one bit per pixel
   localparam int WORD_BITS      = 32;
   localparam int WORDS_PER_LINE = BOX_WIDTH / WORD_BITS;     // 24
   localparam int REQ_HALF       = WORD_BITS / 2;
   localparam int PRE0_REQ_START = H_BOX_OFFSET - 48;         // First word into hold
   localparam int PRE_LOAD_POS   = H_BOX_OFFSET - 33;         // Hold to shift register
   localparam int PRE1_REQ_START = H_BOX_OFFSET - 32;         // Second word into hold

   typedef logic [10:0] screen_coord_t;
   typedef logic [14:0] vram_addr_t;
   typedef logic [31:0] vram_word_t;

endpackage

// ==== vga_regs_pkg.sv ====
// Register map and colour types
package vga_regs_pkg;

   typedef logic [2:0]  rgb_t;       // Red 2, green 1, blue 0
   typedef logic [2:0]  reg_addr_t;
   typedef logic [31:0] wb_data_t;

   localparam int WB_SEL_WIDTH = 4;

   // ========================================
   // Register addresses
   // ========================================
   localparam reg_addr_t REG_CTRL         = 3'd0;  // Bit 0 enable
   localparam reg_addr_t REG_BASE         = 3'd1;
   localparam reg_addr_t REG_FG_COLOR     = 3'd2;
   localparam reg_addr_t REG_BG_COLOR     = 3'd3;
   localparam reg_addr_t REG_BORDER_COLOR = 3'd4;

   // Colours
   localparam rgb_t COLOR_BLACK = 3'b000;
   localparam rgb_t COLOR_WHITE = 3'b111;

   // Values after reset
   localparam rgb_t FG_RESET     = COLOR_WHITE;
   localparam rgb_t BG_RESET     = COLOR_BLACK;
   localparam rgb_t BORDER_RESET = COLOR_WHITE;

endpackage

// ==== vga_sync_gen.sv ====
// VGA sync generator
`timescale 1ns/1ns

module vga_sync_gen
   import vga_timing_pkg::*;
(
   input  logic          pixclk,
   input  logic          reset,
   output screen_coord_t h_count,
   output screen_coord_t v_count,
   output logic          line_end,
   output logic          hsync,
   output logic          vsync,
   output logic          visible,
   output logic          in_box,
   output logic          in_border,
   output logic          v_in_box,
   output screen_coord_t box_x
);

   logic h_in_box;
   logic h_on_edge;
   logic v_on_edge;
   logic h_in_ring;
   logic v_in_ring;

   // ========================================
   // Counters
   // ========================================
   assign line_end = (h_count == screen_coord_t'(H_TOTAL - 1));

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         h_count <= '0;
      else if (line_end)
         h_count <= '0;
      else
         h_count <= h_count + 1'b1;
   end

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         v_count <= '0;
      else if (line_end)
      begin
         if (v_count == screen_coord_t'(V_TOTAL - 1))
            v_count <= '0;
         else
            v_count <= v_count + 1'b1;
      end
   end

   // ========================================
   // Decode
   // ========================================
   assign hsync   = (h_count >= H_SYNC_START) && (h_count < H_SYNC_START + H_SYNC);
   assign vsync   = (v_count >= V_SYNC_START) && (v_count < V_SYNC_START + V_SYNC);
   assign visible = (h_count < H_DISP) && (v_count < V_DISP);

   assign h_in_box = (h_count >= H_BOX_OFFSET) && (h_count < H_BOX_END);
   assign v_in_box = (v_count >= V_BOX_OFFSET) && (v_count < V_BOX_END);
   assign in_box   = visible && h_in_box && v_in_box;

   // One pixel ring around the box
   assign h_on_edge = (h_count == H_BOX_OFFSET - 1) || (h_count == H_BOX_END);
   assign v_on_edge = (v_count == V_BOX_OFFSET - 1) || (v_count == V_BOX_END);
   assign h_in_ring = (h_count >= H_BOX_OFFSET - 1) && (h_count <= H_BOX_END);
   assign v_in_ring = (v_count >= V_BOX_OFFSET - 1) && (v_count <= V_BOX_END);

   assign in_border = visible && ((h_on_edge && v_in_ring) || (v_on_edge && h_in_ring));

   // Column inside the box, follows h_count from the left edge
   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         box_x <= '0;
      else if (h_in_box)
         box_x <= box_x + 1'b1;
      else
         box_x <= '0;
   end

endmodule

// ==== vga_pixel_fetch.sv ====
// Frame buffer pixel fetch
`timescale 1ns/1ns

module vga_pixel_fetch
   import vga_timing_pkg::*;
(
   input  logic          pixclk,
   input  logic          reset,
   input  screen_coord_t h_count,
   input  screen_coord_t box_x,
   input  logic          in_box,
   input  logic          v_in_box,
   input  logic          line_end,
   input  logic          enable,
   input  vram_addr_t    frame_base,
   input  vram_word_t    vram_data,
   input  logic          vram_ready,
   output vram_addr_t    vram_addr,
   output logic          vram_req,
   output logic          pixel
);

   vram_word_t hold_word;
   vram_word_t shift_word;
   logic       hold_empty;
   logic       line_enable;
   vram_addr_t line_addr;
   logic [4:0] fetch_idx;      // Words fetched on this line
   logic [4:0] word_pos;
   logic       pre0_window;
   logic       pre1_window;
   logic       box_window;
   logic       fetch_due;
   logic       preload;
   logic       shift_load;
   logic       capture;

   // ========================================
   // Fetch schedule
   // ========================================
   assign word_pos = box_x[4:0];

   assign pre0_window = (h_count >= PRE0_REQ_START) && (h_count < PRE_LOAD_POS);
   assign pre1_window = (h_count >= PRE1_REQ_START) && (h_count < H_BOX_OFFSET);
   assign box_window  = in_box && (word_pos >= 5'(REQ_HALF));   // Second half of word

   assign fetch_due = line_enable && v_in_box && (fetch_idx < 5'(WORDS_PER_LINE)) &&
                      (pre0_window || pre1_window || box_window);

   assign preload    = v_in_box && (h_count == PRE_LOAD_POS);
   assign shift_load = preload || (in_box && (word_pos == 5'(WORD_BITS - 1)));
   assign capture    = vram_req && vram_ready && hold_empty;

   // Enable only changes between lines
   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         line_enable <= 1'b0;
      else if (line_end)
         line_enable <= enable;
   end

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         line_addr <= '0;
      else if (line_end)
      begin
         if (v_in_box)
            line_addr <= line_addr + vram_addr_t'(WORDS_PER_LINE);
         else
            line_addr <= frame_base;   // Ready for the top of the box
      end
   end

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         fetch_idx <= '0;
      else if (line_end)
         fetch_idx <= '0;
      else if (capture)
         fetch_idx <= fetch_idx + 1'b1;
   end

   // ========================================
   // VRAM request and hold register
   // ========================================
   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         vram_req <= 1'b0;
      else if (capture || line_end)
         vram_req <= 1'b0;
      else
         vram_req <= fetch_due && hold_empty;
   end

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         hold_empty <= 1'b1;
      else if (line_end)
         hold_empty <= 1'b1;
      else if (capture)
         hold_empty <= 1'b0;
      else if (shift_load)
         hold_empty <= 1'b1;
   end

   always_ff @(posedge pixclk)
   begin
      if (capture)
         hold_word <= vram_data;
      if (shift_load)
         shift_word <= hold_word;
      else if (in_box)
         shift_word <= {1'b0, shift_word[31:1]};   // LSB first
   end

   assign vram_addr = line_addr + vram_addr_t'(fetch_idx);
   assign pixel     = line_enable && shift_word[0];

endmodule

// ==== vga_ctrl_regs.sv ====
// Wishbone control registers
`timescale 1ns/1ns

module vga_ctrl_regs
   import vga_timing_pkg::*;
   import vga_regs_pkg::*;
(
   input  logic                    pixclk,
   input  logic                    reset,
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  reg_addr_t               wb_adr,
   input  wb_data_t                wb_dat_w,
   input  logic [WB_SEL_WIDTH-1:0] wb_sel,
   output wb_data_t                wb_dat_r,
   output logic                    wb_ack,
   output logic                    enable,
   output vram_addr_t              frame_base,
   output rgb_t                    fg_color,
   output rgb_t                    bg_color,
   output rgb_t                    border_color
);

   logic     access;
   logic     wr_strobe;
   wb_data_t rd_data;

   // Single cycle ack, one cycle after the request
   assign access    = wb_cyc && wb_stb && !wb_ack;
   assign wr_strobe = access && wb_we;

   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= access;
   end

   // ========================================
   // Register writes
   // ========================================
   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
      begin
         enable       <= 1'b0;
         frame_base   <= '0;
         fg_color     <= FG_RESET;
         bg_color     <= BG_RESET;
         border_color <= BORDER_RESET;
      end
      else if (wr_strobe)
      begin
         case (wb_adr)
            REG_CTRL:
               if (wb_sel[0]) enable <= wb_dat_w[0];
            REG_BASE:
            begin
               if (wb_sel[0]) frame_base[7:0]  <= wb_dat_w[7:0];
               if (wb_sel[1]) frame_base[14:8] <= wb_dat_w[14:8];
            end
            REG_FG_COLOR:
               if (wb_sel[0]) fg_color <= wb_dat_w[2:0];
            REG_BG_COLOR:
               if (wb_sel[0]) bg_color <= wb_dat_w[2:0];
            REG_BORDER_COLOR:
               if (wb_sel[0]) border_color <= wb_dat_w[2:0];
            default: ;   // Unmapped
         endcase
      end
   end

   // Read back
   always_comb
   begin
      rd_data = '0;
      case (wb_adr)
         REG_CTRL:         rd_data[0]   = enable;
         REG_BASE:         rd_data      = wb_data_t'(frame_base);
         REG_FG_COLOR:     rd_data[2:0] = fg_color;
         REG_BG_COLOR:     rd_data[2:0] = bg_color;
         REG_BORDER_COLOR: rd_data[2:0] = border_color;
         default:          rd_data      = '0;
      endcase
   end

   always_ff @(posedge pixclk)
   begin
      if (access)
         wb_dat_r <= rd_data;
   end

endmodule

// ==== vga_pixel_out.sv ====
// VGA output stage
`timescale 1ns/1ns

module vga_pixel_out
   import vga_regs_pkg::*;
(
   input  logic pixclk,
   input  logic reset,
   input  logic hsync,
   input  logic vsync,
   input  logic visible,
   input  logic in_box,
   input  logic in_border,
   input  logic pixel,
   input  rgb_t fg_color,
   input  rgb_t bg_color,
   input  rgb_t border_color,
   output logic vga_hsync,
   output logic vga_vsync,
   output logic vga_blank,
   output rgb_t vga_rgb
);

   rgb_t color_next;

   always_comb
   begin
      if (in_box)
         color_next = pixel ? fg_color : bg_color;
      else if (visible && in_border)
         color_next = border_color;
      else
         color_next = COLOR_BLACK;   // Outside box and during blank
   end

   // All outputs share one register stage
   always_ff @(posedge pixclk or posedge reset)
   begin
      if (reset)
      begin
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b1;
         vga_rgb   <= COLOR_BLACK;
      end
      else
      begin
         vga_hsync <= ~hsync;   // Negative syncs
         vga_vsync <= ~vsync;
         vga_blank <= ~visible;
         vga_rgb   <= color_next;
      end
   end

endmodule

// ==== vga_display_top.sv ====
// Frame buffer display top
`timescale 1ns/1ns

module vga_display_top
   import vga_timing_pkg::*;
   import vga_regs_pkg::*;
(
   input  logic                    pixclk,
   input  logic                    reset,
   // Wishbone slave
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  reg_addr_t               wb_adr,
   input  wb_data_t                wb_dat_w,
   input  logic [WB_SEL_WIDTH-1:0] wb_sel,
   output wb_data_t                wb_dat_r,
   output logic                    wb_ack,
   // VRAM
   output vram_addr_t              vram_addr,
   input  vram_word_t              vram_data,
   output logic                    vram_req,
   input  logic                    vram_ready,
   // VGA
   output logic                    vga_hsync,
   output logic                    vga_vsync,
   output logic                    vga_blank,
   output rgb_t                    vga_rgb
);

   screen_coord_t h_count;
   screen_coord_t box_x;
   logic          line_end;
   logic          hsync;
   logic          vsync;
   logic          visible;
   logic          in_box;
   logic          in_border;
   logic          v_in_box;
   logic          pixel;
   logic          enable;
   vram_addr_t    frame_base;
   rgb_t          fg_color;
   rgb_t          bg_color;
   rgb_t          border_color;

   // ========================================
   // Timing and fetch
   // ========================================
   vga_sync_gen sync_gen (
      .pixclk    (pixclk),
      .reset     (reset),
      .h_count   (h_count),
      .v_count   (),
      .line_end  (line_end),
      .hsync     (hsync),
      .vsync     (vsync),
      .visible   (visible),
      .in_box    (in_box),
      .in_border (in_border),
      .v_in_box  (v_in_box),
      .box_x     (box_x)
   );

   vga_pixel_fetch pixel_fetch (
      .pixclk     (pixclk),
      .reset      (reset),
      .h_count    (h_count),
      .box_x      (box_x),
      .in_box     (in_box),
      .v_in_box   (v_in_box),
      .line_end   (line_end),
      .enable     (enable),
      .frame_base (frame_base),
      .vram_data  (vram_data),
      .vram_ready (vram_ready),
      .vram_addr  (vram_addr),
      .vram_req   (vram_req),
      .pixel      (pixel)
   );

   // ========================================
   // Registers and output stage
   // ========================================
   vga_ctrl_regs ctrl_regs (
      .pixclk       (pixclk),
      .reset        (reset),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_sel       (wb_sel),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .enable       (enable),
      .frame_base   (frame_base),
      .fg_color     (fg_color),
      .bg_color     (bg_color),
      .border_color (border_color)
   );

   vga_pixel_out pixel_out (
      .pixclk       (pixclk),
      .reset        (reset),
      .hsync        (hsync),
      .vsync        (vsync),
      .visible      (visible),
      .in_box       (in_box),
      .in_border    (in_border),
      .pixel        (pixel),
      .fg_color     (fg_color),
      .bg_color     (bg_color),
      .border_color (border_color),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .vga_blank    (vga_blank),
      .vga_rgb      (vga_rgb)
   );

endmodule

// ==== tb_vram_model.sv ====
// Testbench VRAM model
`timescale 1ns/1ns

module tb_vram_model
   import vga_timing_pkg::*;
(
   input  logic       pixclk,
   input  logic       reset,
   input  vram_addr_t vram_addr,
   input  logic       vram_req,
   output vram_word_t vram_data,
   output logic       vram_ready
);

   integer seed;
   logic   busy;
   int     wait_cnt;

   initial seed = 77219;

   // Address in the upper half, its inverse in the lower half
   function automatic vram_word_t word_at(input vram_addr_t a);
      word_at = {1'b0, a, ~{1'b0, a}};
   endfunction

   always @(posedge pixclk or posedge reset)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         wait_cnt   <= 0;
         vram_ready <= 1'b0;
         vram_data  <= '0;
      end
      else
      begin
         vram_ready <= 1'b0;
         if (busy)
         begin
            if (wait_cnt <= 1)
            begin
               busy       <= 1'b0;
               vram_ready <= 1'b1;
               vram_data  <= word_at(vram_addr);
            end
            else
               wait_cnt <= wait_cnt - 1;
         end
         else if (vram_req && !vram_ready)   // New request, latency 1 to 4
         begin
            busy     <= 1'b1;
            wait_cnt <= 1 + ($unsigned($random(seed)) % 4);
         end
      end
   end

endmodule

// ==== tb_vga_display.sv ====
// Display controller testbench
`timescale 1ns/1ns

module tb_vga_display
   import vga_regs_pkg::*;
();

   // ========================================
   // Expected timing and box geometry
   // ========================================
   localparam int H_TOTAL_EXP  = 1596;
   localparam int H_SYNC_EXP   = 100;
   localparam int H_DISP_EXP   = 1280;
   localparam int V_TOTAL_EXP  = 1066;
   localparam int V_SYNC_EXP   = 3;
   localparam int BOX_X0       = 256;
   localparam int BOX_Y0       = 64;
   localparam int BOX_W        = 768;
   localparam int BOX_H        = 896;
   localparam int LINE_WORDS   = 24;
   localparam int FRAME_CYCLES = H_TOTAL_EXP * V_TOTAL_EXP;
   localparam int NUM_ROWS     = 3;
   localparam int CYCLE_LIMIT  = 3 * FRAME_CYCLES * NUM_ROWS + 3 * FRAME_CYCLES;

   localparam int SEL_HSYNC = 0;
   localparam int SEL_BLANK = 1;
   localparam int SEL_VSYNC = 2;

   // Register values to write and the lines to compare
   typedef struct packed {
      logic [31:0] ctrl;
      logic [31:0] base;
      logic [31:0] fg;
      logic [31:0] bg;
      logic [31:0] border;
      logic [15:0] y0;
      logic [15:0] nlines;
   } row_t;

   logic        pixclk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   wb_data_t    wb_dat_w;
   logic [3:0]  wb_sel;
   wb_data_t    wb_dat_r;
   logic        wb_ack;
   logic [14:0] vram_addr;
   logic [31:0] vram_data;
   logic        vram_req;
   logic        vram_ready;
   logic        vga_hsync;
   logic        vga_vsync;
   logic        vga_blank;
   rgb_t        vga_rgb;

   row_t rows [NUM_ROWS];
   int   errors = 0;
   int   checks = 0;
   int   tests  = 0;
   int   cycles = 0;

   vga_display_top uut (
      .pixclk     (pixclk),
      .reset      (reset),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .vram_addr  (vram_addr),
      .vram_data  (vram_data),
      .vram_req   (vram_req),
      .vram_ready (vram_ready),
      .vga_hsync  (vga_hsync),
      .vga_vsync  (vga_vsync),
      .vga_blank  (vga_blank),
      .vga_rgb    (vga_rgb)
   );

   tb_vram_model vram (
      .pixclk     (pixclk),
      .reset      (reset),
      .vram_addr  (vram_addr),
      .vram_req   (vram_req),
      .vram_data  (vram_data),
      .vram_ready (vram_ready)
   );

   initial
   begin
      pixclk = 1'b0;
      forever #4 pixclk = ~pixclk;
   end

   always @(posedge pixclk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout, run stopped after %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   // ========================================
   // Helpers
   // ========================================
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // Starts on a falling edge and returns on the falling edge that sees ack
   task automatic wb_access(input logic we, input reg_addr_t adr,
                            input logic [31:0] data, output logic [31:0] rdata);
      int n;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      wb_sel   = 4'hF;
      n = 0;
      do
      begin
         @(negedge pixclk);
         n++;
      end
      while (!wb_ack && n < 16);
      if (!wb_ack)
      begin
         errors++;
         $display("Wishbone access to address %0d got no ack", adr);
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_readback(input reg_addr_t adr, input logic [31:0] data,
                                 input logic [31:0] mask, input string name);
      logic [31:0] rd;
      wb_access(1'b1, adr, data, rd);
      wb_access(1'b0, adr, 32'h0, rd);
      check_value(name, rd, data & mask);
   endtask

   function automatic logic out_level(input int which);
      case (which)
         SEL_HSYNC: out_level = vga_hsync;
         SEL_BLANK: out_level = vga_blank;
         default:   out_level = vga_vsync;
      endcase
   endfunction

   // Falling edges until the output reaches the level
   task automatic count_until(input int which, input logic level, output int n);
      n = 0;
      while (out_level(which) !== level)
      begin
         @(negedge pixclk);
         n++;
      end
   endtask

   function automatic logic [31:0] expected_word(input logic [14:0] a);
      expected_word = {1'b0, a, ~{1'b0, a}};
   endfunction

   function automatic logic [2:0] expected_rgb(input int r, input int x, input int y);
      int          bx;
      int          by;
      logic [14:0] addr;
      logic [31:0] word;
      bx = x - BOX_X0;
      by = y - BOX_Y0;
      if (bx >= 0 && bx < BOX_W && by >= 0 && by < BOX_H)
      begin
         addr = rows[r].base[14:0] + 15'(LINE_WORDS * by + bx / 32);
         word = expected_word(addr);
         if (rows[r].ctrl[0] && word[bx % 32])
            expected_rgb = rows[r].fg[2:0];
         else
            expected_rgb = rows[r].bg[2:0];
      end
      else if (((bx == -1 || bx == BOX_W) && by >= -1 && by <= BOX_H) ||
               ((by == -1 || by == BOX_H) && bx >= -1 && bx <= BOX_W))
         expected_rgb = rows[r].border[2:0];
      else
         expected_rgb = 3'b000;
   endfunction

   // One frame from vsync rising with positions counted from the blank edges
   task automatic check_frame(input int r);
      int          n;
      int          x;
      int          y;
      int          k;
      int          y_lo;
      int          y_hi;
      logic        prev_blank;
      logic        req_seen;
      logic [14:0] exp_addr;
      y_lo = int'(rows[r].y0);
      y_hi = y_lo + int'(rows[r].nlines);
      count_until(SEL_VSYNC, 1'b0, n);
      count_until(SEL_VSYNC, 1'b1, n);
      x = 0;
      y = -1;
      k = 0;
      prev_blank = 1'b1;
      req_seen = 1'b0;
      while (vga_vsync === 1'b1)
      begin
         @(negedge pixclk);
         if (vram_req)
            req_seen = 1'b1;
         if (prev_blank && !vga_blank)
         begin
            x = 0;
            y++;
            k = 0;
         end
         else if (!vga_blank)
            x++;
         prev_blank = vga_blank;
         if (vram_req && vram_ready)   // Word k of the current line
         begin
            exp_addr = rows[r].base[14:0] + 15'(LINE_WORDS * (y - BOX_Y0) + k);
            if (y >= y_lo && y < y_hi)
               check_value("vram_addr", vram_addr, exp_addr);
            k++;
         end
         if (y >= y_lo && y < y_hi)
            check_value($sformatf("vga_rgb at (%0d,%0d)", x, y), vga_rgb,
                        vga_blank ? 3'b000 : expected_rgb(r, x, y));
      end
      if (!rows[r].ctrl[0])
         check_value("vram_req while disabled", req_seen, 1'b0);
   endtask

   task automatic finish_test(input string name, input int mark);
      tests++;
      $display("Test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "errors");
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial
   begin
      int          r;
      int          mark;
      int          low;
      int          high;
      logic [31:0] rd;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;

      rows[0] = {32'hFFFF_FFFF, 32'hABCD_0120, 32'h0000_00F2, 32'h1234_5675,
                 32'h0000_000C, 16'd62, 16'd4};     // Top border and first box lines
      rows[1] = {32'h0000_0003, 32'h0000_7F80, 32'hFFFF_FFF9, 32'h0000_0006,
                 32'h0000_0003, 16'd957, 16'd6};    // Bottom border and address wrap
      rows[2] = {32'hFFFF_FFFE, 32'h0000_0040, 32'h0000_0007, 32'h0000_0003,
                 32'h0000_0002, 16'd300, 16'd3};    // Disabled

      mark = errors;
      repeat (2) @(negedge pixclk);
      check_value("vga_hsync", vga_hsync, 1'b1);
      check_value("vga_vsync", vga_vsync, 1'b1);
      check_value("vga_blank", vga_blank, 1'b1);
      check_value("vga_rgb", vga_rgb, 3'b000);
      check_value("vram_req", vram_req, 1'b0);
      check_value("wb_ack", wb_ack, 1'b0);
      reset = 1'b0;
      wb_access(1'b0, REG_CTRL, 32'h0, rd);
      check_value("CTRL after reset", rd, 32'h0);
      wb_access(1'b0, REG_BASE, 32'h0, rd);
      check_value("BASE after reset", rd, 32'h0);
      wb_access(1'b0, REG_FG_COLOR, 32'h0, rd);
      check_value("FG after reset", rd, 32'h7);
      wb_access(1'b0, REG_BG_COLOR, 32'h0, rd);
      check_value("BG after reset", rd, 32'h0);
      wb_access(1'b0, REG_BORDER_COLOR, 32'h0, rd);
      check_value("BORDER after reset", rd, 32'h7);
      finish_test("reset values", mark);

      mark = errors;
      write_readback(3'd5, 32'hFFFF_FFFF, 32'h0, "unmapped 5");
      wb_access(1'b0, 3'd6, 32'h0, rd);
      check_value("unmapped 6", rd, 32'h0);
      wb_access(1'b0, 3'd7, 32'h0, rd);
      check_value("unmapped 7", rd, 32'h0);
      finish_test("unmapped addresses", mark);

      mark = errors;
      count_until(SEL_HSYNC, 1'b1, low);
      count_until(SEL_HSYNC, 1'b0, low);
      count_until(SEL_HSYNC, 1'b1, low);
      count_until(SEL_HSYNC, 1'b0, high);
      check_value("hsync low cycles", low, H_SYNC_EXP);
      check_value("hsync period", low + high, H_TOTAL_EXP);
      count_until(SEL_BLANK, 1'b1, low);
      count_until(SEL_BLANK, 1'b0, low);
      count_until(SEL_BLANK, 1'b1, low);
      check_value("blank low cycles", low, H_DISP_EXP);
      count_until(SEL_VSYNC, 1'b1, low);
      count_until(SEL_VSYNC, 1'b0, low);
      count_until(SEL_VSYNC, 1'b1, low);
      count_until(SEL_VSYNC, 1'b0, high);
      check_value("vsync low cycles", low, V_SYNC_EXP * H_TOTAL_EXP);
      check_value("frame cycles", low + high, V_TOTAL_EXP * H_TOTAL_EXP);
      finish_test("sync timing", mark);

      for (r = 0; r < NUM_ROWS; r++)
      begin
         mark = errors;
         write_readback(REG_CTRL, rows[r].ctrl, 32'h1, "CTRL");
         write_readback(REG_BASE, rows[r].base, 32'h7FFF, "BASE");
         write_readback(REG_FG_COLOR, rows[r].fg, 32'h7, "FG");
         write_readback(REG_BG_COLOR, rows[r].bg, 32'h7, "BG");
         write_readback(REG_BORDER_COLOR, rows[r].border, 32'h7, "BORDER");
         check_frame(r);
         finish_test($sformatf("frame row %0d", r), mark);
      end

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== compile.f ====
vga_timing_pkg.sv
vga_regs_pkg.sv
vga_sync_gen.sv
vga_pixel_fetch.sv
vga_ctrl_regs.sv
vga_pixel_out.sv
vga_display_top.sv
tb_vram_model.sv
tb_vga_display.sv

// ==== Bender.yml ====
package:
  name: vga_display

sources:
  - vga_timing_pkg.sv
  - vga_regs_pkg.sv
  - vga_sync_gen.sv
  - vga_pixel_fetch.sv
  - vga_ctrl_regs.sv
  - vga_pixel_out.sv
  - vga_display_top.sv
  - target: test
    files:
      - tb_vram_model.sv
      - tb_vga_display.sv
